// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = tb_cache_bist
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cache.sv
// direct-mapped write-back cache
// one doubleword per request, line-wide memory port

`timescale 1ns/1ps

module cache import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cache_req,
  input  req_op_e           i_cache_op,
  input  logic [ADDR_W-1:0] i_cache_addr,
  input  logic [WORD_W-1:0] i_cache_wdata,
  output logic              o_cache_ack,
  output logic [WORD_W-1:0] o_cache_rdata,
  input  logic              i_mem_ready,
  input  logic [LINE_W-1:0] i_mem_rdata,
  output logic              o_mem_valid,
  output req_op_e           o_mem_op,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [LINE_W-1:0] o_mem_wdata
);

  localparam int OFFSET_W = ADDR_W - TAG_W - INDEX_W;  // byte offset in a line

  cache_state_e state;

  // latched request
  logic [ADDR_W-1:0]     req_addr;
  req_op_e               req_op;
  logic [WORD_W-1:0]     req_wdata;
  logic [TAG_W-1:0]      req_tag;
  logic [INDEX_W-1:0]    req_index;
  logic [WORD_SEL_W-1:0] req_word_sel;

  // current line
  logic [TAG_W-1:0]  line_tag;
  logic              line_valid;
  logic              line_dirty;
  logic [LINE_W-1:0] line_data;
  logic [WORD_W-1:0] line_word;

  logic              hit;
  logic              wr_word;
  logic              fill_done;
  logic [ADDR_W-1:0] fill_addr;
  logic [ADDR_W-1:0] victim_addr;

  assign req_tag      = req_addr[ADDR_W-1 -: TAG_W];
  assign req_index    = req_addr[OFFSET_W +: INDEX_W];
  assign req_word_sel = req_addr[3 +: WORD_SEL_W];

  assign hit         = line_valid && (line_tag == req_tag);
  assign wr_word     = (state == C_ACK) && (req_op == REQ_WRITE);  // merge in ack cycle
  assign fill_done   = (state == C_FILL) && o_mem_valid && i_mem_ready;
  assign fill_addr   = {req_tag, req_index, {OFFSET_W{1'b0}}};
  assign victim_addr = {line_tag, req_index, {OFFSET_W{1'b0}}};

  cache_line_store u_store (
    .clk         (clk),
    .rst         (rst),
    .i_index     (req_index),
    .i_word_sel  (req_word_sel),
    .i_wr_word   (wr_word),
    .i_wdata     (req_wdata),
    .i_dirty_set (req_op == REQ_WRITE),
    .i_fill      (fill_done),
    .i_fill_tag  (req_tag),
    .i_fill_line (i_mem_rdata),
    .o_tag       (line_tag),
    .o_valid     (line_valid),
    .o_dirty     (line_dirty),
    .o_line      (line_data),
    .o_rdata     (line_word)
  );

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= C_IDLE;
      o_mem_valid <= 1'b0;
    end else begin
      case (state)
        C_IDLE: begin
          if (i_cache_req) state <= C_LOOKUP;
        end
        C_LOOKUP: begin
          if (hit) begin
            state <= C_ACK;
          end else if (line_valid && line_dirty) begin
            o_mem_valid <= 1'b1;  // writeback first
            state       <= C_WBACK;
          end else begin
            state <= C_FILL;
          end
        end
        C_WBACK: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state       <= C_FILL;
          end
        end
        C_FILL: begin
          if (!o_mem_valid) begin
            o_mem_valid <= 1'b1;  // raise read one cycle after entry
          end else if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state       <= C_ACK;
          end
        end
        C_ACK:   state <= C_IDLE;
        default: state <= C_IDLE;
      endcase
    end
  end

  // request and memory payload
  always_ff @(posedge clk) begin
    if (state == C_IDLE && i_cache_req) begin
      req_addr  <= i_cache_addr;
      req_op    <= i_cache_op;
      req_wdata <= i_cache_wdata;
    end
    if (state == C_LOOKUP && !hit) begin
      if (line_valid && line_dirty) begin
        o_mem_op    <= REQ_WRITE;
        o_mem_addr  <= victim_addr;  // victim's own line address
        o_mem_wdata <= line_data;
      end else begin
        o_mem_op   <= REQ_READ;
        o_mem_addr <= fill_addr;
      end
    end
    if (state == C_WBACK && i_mem_ready) begin
      o_mem_op   <= REQ_READ;
      o_mem_addr <= fill_addr;
    end
  end

  assign o_cache_ack   = (state == C_ACK);
  assign o_cache_rdata = line_word;  // line already filled by ack

endmodule

// File: cache_bist_top.sv
// cache self-test top level

`timescale 1ns/1ps

module cache_bist_top import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_mem_ready,
  input  logic [LINE_W-1:0] i_mem_rdata,
  output logic              o_mem_valid,
  output req_op_e           o_mem_op,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [LINE_W-1:0] o_mem_wdata,
  output logic [CNT_W-1:0]  o_pass_cnt,
  output logic [CNT_W-1:0]  o_err_cnt
);

  // generator to cache
  logic              cache_req;
  req_op_e           cache_op;
  logic [ADDR_W-1:0] cache_addr;
  logic [WORD_W-1:0] cache_wdata;
  logic              cache_ack;
  logic [WORD_W-1:0] cache_rdata;

  cache_test_gen u_gen (
    .clk           (clk),
    .rst           (rst),
    .i_cache_ack   (cache_ack),
    .i_cache_rdata (cache_rdata),
    .o_cache_req   (cache_req),
    .o_cache_op    (cache_op),
    .o_cache_addr  (cache_addr),
    .o_cache_wdata (cache_wdata),
    .o_pass_cnt    (o_pass_cnt),
    .o_err_cnt     (o_err_cnt)
  );

  cache u_cache (
    .clk           (clk),
    .rst           (rst),
    .i_cache_req   (cache_req),
    .i_cache_op    (cache_op),
    .i_cache_addr  (cache_addr),
    .i_cache_wdata (cache_wdata),
    .o_cache_ack   (cache_ack),
    .o_cache_rdata (cache_rdata),
    .i_mem_ready   (i_mem_ready),
    .i_mem_rdata   (i_mem_rdata),
    .o_mem_valid   (o_mem_valid),
    .o_mem_op      (o_mem_op),
    .o_mem_addr    (o_mem_addr),
    .o_mem_wdata   (o_mem_wdata)
  );

endmodule

// File: cache_line_store.sv
// cache line arrays

`timescale 1ns/1ps

module cache_line_store import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_W-1:0]    i_index,
  input  logic [WORD_SEL_W-1:0] i_word_sel,
  input  logic                  i_wr_word,
  input  logic [WORD_W-1:0]     i_wdata,
  input  logic                  i_dirty_set,
  input  logic                  i_fill,
  input  logic [TAG_W-1:0]      i_fill_tag,
  input  logic [LINE_W-1:0]     i_fill_line,
  output logic [TAG_W-1:0]      o_tag,
  output logic                  o_valid,
  output logic                  o_dirty,
  output logic [LINE_W-1:0]     o_line,
  output logic [WORD_W-1:0]     o_rdata
);

  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [LINE_W-1:0]    data_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;
  logic [NUM_LINES-1:0] dirty_bits;

  // per-line status
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (i_fill) begin
      valid_bits[i_index] <= 1'b1;
      dirty_bits[i_index] <= 1'b0;  // fresh copy from memory
    end else if (i_wr_word && i_dirty_set) begin
      dirty_bits[i_index] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (i_fill) begin
      tag_mem[i_index]  <= i_fill_tag;
      data_mem[i_index] <= i_fill_line;
    end else if (i_wr_word) begin
      data_mem[i_index][i_word_sel*WORD_W +: WORD_W] <= i_wdata;  // merge one doubleword
    end
  end

  // lookup is combinational from the index
  assign o_tag   = tag_mem[i_index];
  assign o_valid = valid_bits[i_index];
  assign o_dirty = dirty_bits[i_index];
  assign o_line  = data_mem[i_index];
  assign o_rdata = data_mem[i_index][i_word_sel*WORD_W +: WORD_W];

endmodule

// File: cache_pkg.sv
// cache subsystem shared definitions

package cache_pkg;

  // bus and line widths
  localparam int ADDR_W = 64;
  localparam int WORD_W = 64;
  localparam int LINE_W = 512;

  // direct-mapped geometry, 8 lines of 64 bytes
  localparam int NUM_LINES  = 8;
  localparam int INDEX_W    = 3;
  localparam int WORD_SEL_W = 3;
  localparam int TAG_W      = ADDR_W - 9;  // above index and line offset

  // traffic generator window, twice the cache size
  localparam logic [ADDR_W-1:0] WIN_BASE = 64'h0000_0000_8000_0000;
  localparam logic [ADDR_W-1:0] WIN_LAST = 64'h0000_0000_8000_03F8;

  localparam int GAP_CYCLES = 10;  // idle cycles before each request
  localparam int CNT_W      = 16;

  // test words, picked by doubleword index plus pass number
  localparam logic [WORD_W-1:0] PATTERN [8] = '{
    64'h8c2078a7_07e5484d,
    64'h4765af4e_5226ec81,
    64'h8046a887_4f66de44,
    64'h24334404_8c940a7d,
    64'h01dec340_02e85dec,
    64'h9bb5df90_9d43c9b6,
    64'h2b9b566d_5c040a78,
    64'h196df530_aeb93dad
  };

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  typedef enum logic [2:0] {
    C_IDLE,
    C_LOOKUP,
    C_WBACK,
    C_FILL,
    C_ACK
  } cache_state_e;

  typedef enum logic [1:0] {
    G_GAP,
    G_REQ,
    G_NEXT
  } gen_state_e;

endpackage

// File: cache_test_gen.sv
// cache traffic generator
// write sweep, read sweep and compare, then next pattern

`timescale 1ns/1ps

module cache_test_gen import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cache_ack,
  input  logic [WORD_W-1:0] i_cache_rdata,
  output logic              o_cache_req,
  output req_op_e           o_cache_op,
  output logic [ADDR_W-1:0] o_cache_addr,
  output logic [WORD_W-1:0] o_cache_wdata,
  output logic [CNT_W-1:0]  o_pass_cnt,
  output logic [CNT_W-1:0]  o_err_cnt
);

  localparam int GAP_W = $clog2(GAP_CYCLES);

  gen_state_e state;

  logic [GAP_W-1:0] gap_cnt;
  logic [2:0]       pass_idx;  // pattern rotation, wraps at 8
  logic [2:0]       pat_idx;
  logic             mismatch;

  // doubleword index in the window plus pass, mod 8
  assign pat_idx       = o_cache_addr[5:3] + pass_idx;
  assign o_cache_wdata = PATTERN[pat_idx];
  assign mismatch      = i_cache_rdata != PATTERN[pat_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= G_GAP;
      gap_cnt      <= '0;
      o_cache_req  <= 1'b0;
      o_cache_op   <= REQ_WRITE;  // start with a write sweep
      o_cache_addr <= WIN_BASE;
      pass_idx     <= '0;
      o_pass_cnt   <= '0;
      o_err_cnt    <= '0;
    end else begin
      case (state)
        G_GAP: begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1)) begin
            o_cache_req <= 1'b1;
            state       <= G_REQ;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        G_REQ: begin
          if (i_cache_ack) begin
            o_cache_req <= 1'b0;
            gap_cnt     <= GAP_W'(1);  // ack cycle is the first gap cycle
            state       <= G_NEXT;
            if (o_cache_op == REQ_READ && mismatch) begin
              o_err_cnt <= o_err_cnt + 1'b1;
            end
          end
        end
        G_NEXT: begin
          gap_cnt <= gap_cnt + 1'b1;
          state   <= G_GAP;
          if (o_cache_addr == WIN_LAST) begin
            o_cache_addr <= WIN_BASE;
            if (o_cache_op == REQ_READ) begin
              o_cache_op <= REQ_WRITE;
              pass_idx   <= pass_idx + 1'b1;
              o_pass_cnt <= o_pass_cnt + 1'b1;
            end else begin
              o_cache_op <= REQ_READ;  // same pattern read back
            end
          end else begin
            o_cache_addr <= o_cache_addr + ADDR_W'(8);
          end
        end
        default: state <= G_GAP;
      endcase
    end
  end

endmodule

// File: tb.f
cache_pkg.sv
cache_line_store.sv
cache.sv
cache_test_gen.sv
cache_bist_top.sv
tb_mem_model.sv
tb_cache_bist.sv

// File: tb_cache_bist.sv
// cache self-test testbench

`timescale 1ns/1ps

module tb_cache_bist import cache_pkg::*; ();

  localparam int          PASS_LIMIT = 12000;  // cycles allowed per pass
  localparam logic [31:0] LFSR_SEED  = 32'h354c8a96;

  logic              clk;
  logic              rst;
  logic              mem_ready;
  logic [LINE_W-1:0] mem_rdata;
  logic              mem_valid;
  req_op_e           mem_op;
  logic [ADDR_W-1:0] mem_addr;
  logic [LINE_W-1:0] mem_wdata;
  logic [CNT_W-1:0]  pass_cnt;
  logic [CNT_W-1:0]  err_cnt;
  logic [4:0]        mem_delay;
  logic              flip;
  logic [ADDR_W-1:0] flip_addr;

  int          value_errs;
  int          other_fails;
  int          fill_total;
  int          wb_total;
  int          sweep_fills;
  int          sweep_wbs;
  bit          random_mode;
  bit          timed_out;
  logic [31:0] lfsr;

  cache_bist_top uut (
    .clk         (clk),
    .rst         (rst),
    .i_mem_ready (mem_ready),
    .i_mem_rdata (mem_rdata),
    .o_mem_valid (mem_valid),
    .o_mem_op    (mem_op),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_pass_cnt  (pass_cnt),
    .o_err_cnt   (err_cnt)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (mem_valid),
    .i_op        (mem_op),
    .i_addr      (mem_addr),
    .i_wdata     (mem_wdata),
    .i_delay     (mem_delay),
    .i_flip      (flip),
    .i_flip_addr (flip_addr),
    .o_ready     (mem_ready),
    .o_rdata     (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic pick_delay();
    logic [3:0] d;
    d = '0;
    for (int i = 0; i < 4; i++) begin
      lfsr = lfsr_next(lfsr);
      d    = {d[2:0], lfsr[0]};
    end
    mem_delay = {1'b0, d} + 5'd1;  // 1 to 16 cycles
  endtask

  // fills come in window order, one sweep = 16 lines
  task automatic record_fill(input logic [3:0] line);
    if (int'(line) != sweep_fills) begin
      $display("ERR o_mem_addr: got %h expected %h", mem_addr, WIN_BASE + 64'(sweep_fills * 64));
      value_errs++;
    end
    fill_total++;
    sweep_fills++;
    if (sweep_fills == 16) begin
      if (sweep_wbs != 8) begin
        $display("ERR sweep_wbs: got %h expected %h", sweep_wbs, 8);
        value_errs++;
      end
      sweep_fills = 0;
      sweep_wbs   = 0;
    end
  endtask

  // victim is always the line 8 ahead of the next fill
  task automatic check_writeback(input logic [3:0] line);
    int               exp_line;
    int               pass_no;
    logic [2:0]       idx;
    logic [WORD_W-1:0] got;
    exp_line = (sweep_fills + 8) % 16;
    pass_no  = fill_total / 32;  // 32 fills per pass
    wb_total++;
    sweep_wbs++;
    if (fill_total < 8) begin
      $display("writeback seen before the cache held any valid line");
      other_fails++;
    end
    if (int'(line) != exp_line) begin
      $display("ERR o_mem_addr: got %h expected %h", mem_addr, WIN_BASE + 64'(exp_line * 64));
      value_errs++;
    end
    for (int w = 0; w < 8; w++) begin
      idx = 3'((w + pass_no) % 8);
      got = mem_wdata[w*WORD_W +: WORD_W];
      if (got !== PATTERN[idx]) begin
        $display("ERR o_mem_wdata word %0d: got %h expected %h", w, got, PATTERN[idx]);
        value_errs++;
      end
    end
  endtask

  // memory port monitor, valid and ready are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && mem_valid && mem_ready) begin
      if (mem_addr[5:0] != 6'd0 || mem_addr < WIN_BASE || mem_addr > WIN_LAST) begin
        $display("memory access at %h is not an aligned line in the window", mem_addr);
        other_fails++;
      end
      if (mem_op == REQ_WRITE) begin
        check_writeback(mem_addr[9:6]);
      end else begin
        record_fill(mem_addr[9:6]);
      end
      if (random_mode) begin
        pick_delay();
      end
    end
  end

  task automatic wait_fills(input int target, input int limit);
    int n;
    n = 0;
    while (fill_total < target && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (fill_total < target) begin
      $display("timeout with %0d of %0d line fills seen", fill_total, target);
      other_fails++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_passes(input int target, input int limit);
    int n;
    n = 0;
    while (pass_cnt < CNT_W'(target) && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pass_cnt < CNT_W'(target)) begin
      $display("timeout waiting for pass %0d, generator stuck at %0d", target, pass_cnt);
      other_fails++;
      timed_out = 1'b1;
    end
  endtask

  task automatic test_reset_quiet();
    int n;
    n = 0;
    while (!mem_valid && n < 200) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!mem_valid) begin
      $display("timeout, no memory request after reset");
      other_fails++;
      timed_out = 1'b1;
    end else if (n < GAP_CYCLES) begin
      $display("memory request only %0d cycles after reset", n);
      other_fails++;
    end
  endtask

  task automatic test_first_pass();
    wait_passes(1, PASS_LIMIT);
    if (timed_out) return;
    if (err_cnt != 16'd0) begin
      $display("ERR o_err_cnt: got %h expected %h", err_cnt, 16'd0);
      value_errs++;
    end
    if (fill_total != 32 || wb_total != 16) begin
      $display("ERR fill_total/wb_total: got %h/%h expected %h/%h", fill_total, wb_total, 32, 16);
      value_errs++;
    end
  endtask

  // line 2 is already written back by the second write sweep
  task automatic test_fault_injection();
    wait_fills(48, PASS_LIMIT);
    if (timed_out) return;
    flip_addr = WIN_BASE + 64'h98;  // line 2, word 3
    flip      = 1'b1;
    wait_passes(2, PASS_LIMIT);
    if (timed_out) return;
    if (err_cnt != 16'd1) begin
      $display("ERR o_err_cnt: got %h expected %h", err_cnt, 16'd1);
      value_errs++;
    end
    if (pass_cnt != 16'd2) begin
      $display("ERR o_pass_cnt: got %h expected %h", pass_cnt, 16'd2);
      value_errs++;
    end
  endtask

  task automatic test_random_ready();
    lfsr        = LFSR_SEED;
    random_mode = 1'b1;
    pick_delay();
    wait_passes(5, 3 * PASS_LIMIT);
    if (timed_out) return;
    if (err_cnt != 16'd1) begin  // no new mismatches
      $display("ERR o_err_cnt: got %h expected %h", err_cnt, 16'd1);
      value_errs++;
    end
    if (fill_total != 160) begin
      $display("ERR fill_total: got %h expected %h", fill_total, 160);
      value_errs++;
    end
  endtask

  initial begin
    rst         = 1'b1;
    mem_delay   = 5'd4;
    flip        = 1'b0;
    flip_addr   = '0;
    random_mode = 1'b0;
    timed_out   = 1'b0;
    lfsr        = LFSR_SEED;
    value_errs  = 0;
    other_fails = 0;
    fill_total  = 0;
    wb_total    = 0;
    sweep_fills = 0;
    sweep_wbs   = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_quiet();
    if (!timed_out) test_first_pass();
    if (!timed_out) test_fault_injection();
    if (!timed_out) test_random_ready();

    $display("error counts: %0d value errors, %0d other failures", value_errs, other_fails);
    if (value_errs == 0 && other_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tb_mem_model.sv
// testbench line memory for the cache window

`timescale 1ns/1ps

module tb_mem_model import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  input  req_op_e           i_op,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [LINE_W-1:0] i_wdata,
  input  logic [4:0]        i_delay,
  input  logic              i_flip,
  input  logic [ADDR_W-1:0] i_flip_addr,
  output logic              o_ready,
  output logic [LINE_W-1:0] o_rdata
);

  // 16 lines of 8 doublewords, indexed by address bits 9:3
  logic [WORD_W-1:0] mem [128];
  logic [3:0]        mem_line;
  int                wait_cnt;
  bit                flipped;

  initial begin
    for (int i = 0; i < 128; i++) begin
      mem[i] = '0;
    end
    o_ready  = 1'b0;
    o_rdata  = '0;
    wait_cnt = 0;
    flipped  = 1'b0;
    forever begin
      @(posedge clk);
      // fault hook, sampled on the edge so it lands one cycle after it is driven
      if (i_flip && !flipped) begin
        mem[i_flip_addr[9:3]] = mem[i_flip_addr[9:3]] ^ 64'h0000_0000_0000_00ff;
        flipped = 1'b1;
      end
      #1;
      if (rst) begin
        o_ready  = 1'b0;
        wait_cnt = 0;
      end else if (o_ready) begin
        o_ready  = 1'b0;  // one-cycle pulse
        wait_cnt = 0;
      end else if (i_valid) begin
        wait_cnt++;
        if (wait_cnt >= int'(i_delay)) begin
          mem_line = i_addr[9:6];
          if (i_op == REQ_WRITE) begin
            for (int w = 0; w < 8; w++) begin
              mem[{mem_line, 3'(w)}] = i_wdata[w*WORD_W +: WORD_W];
            end
          end else begin
            for (int w = 0; w < 8; w++) begin
              o_rdata[w*WORD_W +: WORD_W] = mem[{mem_line, 3'(w)}];
            end
          end
          o_ready = 1'b1;
        end
      end
    end
  end

endmodule
